// File: exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// datapath and register file sizes
`define EXE_XLEN 32
`define EXE_RA_W 5
`define EXE_OP_W 4

`endif

// File: uop_pkg.sv
`include "exe_defines.svh"

package uop_pkg;

    typedef enum logic [1:0] {
        ITYPE_NONE = 2'd0,
        ITYPE_ALU  = 2'd1,
        ITYPE_BR   = 2'd2,
        ITYPE_MUL  = 2'd3
    } itype_e;

    typedef enum logic [`EXE_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // branch condition codes
    typedef enum logic [`EXE_OP_W-1:0] {
        BR_JIRL = 4'b0011,
        BR_B    = 4'b0100,
        BR_BL   = 4'b0101,
        BR_BEQ  = 4'b0110,
        BR_BNE  = 4'b0111,
        BR_BLT  = 4'b1000,
        BR_BGE  = 4'b1001,
        BR_BLTU = 4'b1010,
        BR_BGEU = 4'b1011
    } br_cond_e;

    typedef struct packed {
        logic       high;
        logic       sgn;
        logic [1:0] spare;
    } mul_kind_t;

    // one op field decoded per itype
    typedef union packed {
        alu_op_e   alu;
        br_cond_e  br;
        mul_kind_t mul;
    } op_u;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

    // producer of the lane 0 mid entry
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_BR   = 2'd2,
        FU_MUL  = 2'd3
    } fu_sel_e;

endpackage

// File: exe_alu.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_alu (
    input  logic                 en,
    input  uop_pkg::alu_op_e     op,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    output logic [`EXE_XLEN-1:0] result
);
    import uop_pkg::*;

    logic [`EXE_XLEN-1:0] res;
    logic [4:0]           shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_SLT:  res = {{(`EXE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: res = {{(`EXE_XLEN-1){1'b0}}, a < b};
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_NOR:  res = ~(a | b);
            ALU_SLL:  res = a << shamt;
            ALU_SRL:  res = a >> shamt;
            ALU_SRA:  res = $signed(a) >>> shamt;
            // upper immediate is prepared by decode
            ALU_LUI:  res = b;
            default:  res = '0;
        endcase
    end

    // idle lane reads as zero
    assign result = en ? res : '0;

endmodule

// File: exe_branch.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_branch (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 en,
    input  uop_pkg::br_cond_e    cond,
    input  logic [`EXE_XLEN-1:0] pc,
    input  logic [`EXE_XLEN-1:0] pc_next,
    input  logic [`EXE_XLEN-1:0] imm,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    output logic                 valid,
    output logic                 taken,
    output logic [`EXE_XLEN-1:0] target,
    output logic [`EXE_XLEN-1:0] link,
    output logic                 mispredict,
    output logic [`EXE_XLEN-1:0] redirect_pc
);
    import uop_pkg::*;

    logic cond_true;

    always_comb begin
        case (cond)
            BR_JIRL, BR_B, BR_BL: cond_true = 1'b1;
            BR_BEQ:  cond_true = (a == b);
            BR_BNE:  cond_true = (a != b);
            BR_BLT:  cond_true = ($signed(a) < $signed(b));
            BR_BGE:  cond_true = ($signed(a) >= $signed(b));
            BR_BLTU: cond_true = (a < b);
            BR_BGEU: cond_true = (a >= b);
            default: cond_true = 1'b0;
        endcase
    end

    assign valid  = en;
    assign taken  = en && cond_true;
    // jirl is register relative
    assign target = (cond == BR_JIRL) ? a + imm : pc + imm;
    assign link   = pc + `EXE_XLEN'(4);

    assign redirect_pc = taken ? target : link;
    assign mispredict  = en && (redirect_pc != pc_next);

    // decode only hands over known branch codes
    a_cond_known: assert property (@(posedge clk) disable iff (!arst_n)
        en |-> cond inside {BR_JIRL, BR_B, BR_BL, BR_BEQ, BR_BNE,
                            BR_BLT, BR_BGE, BR_BLTU, BR_BGEU});

endmodule

// File: exe_mul.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_mul (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 load,
    input  uop_pkg::mul_kind_t   kind,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    output logic [`EXE_XLEN-1:0] product
);
    logic [32:0]        a_ext;
    logic [32:0]        b_ext;
    logic signed [33:0] pp_ll_q;
    logic signed [33:0] pp_lh_q;
    logic signed [33:0] pp_hl_q;
    logic signed [33:0] pp_hh_q;
    logic               high_q;
    logic signed [65:0] sum;

    // 33 bits cover both signed and unsigned operands
    assign a_ext = {kind.sgn & a[31], a};
    assign b_ext = {kind.sgn & b[31], b};

    // low halves are unsigned, upper 17 bits signed
    always_ff @(posedge clk) begin
        if (load) begin
            pp_ll_q <= $signed({1'b0, a_ext[15:0]}) * $signed({1'b0, b_ext[15:0]});
            pp_lh_q <= $signed({1'b0, a_ext[15:0]}) * $signed(b_ext[32:16]);
            pp_hl_q <= $signed(a_ext[32:16]) * $signed({1'b0, b_ext[15:0]});
            pp_hh_q <= $signed(a_ext[32:16]) * $signed(b_ext[32:16]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            high_q <= 1'b0;
        end else if (load) begin
            high_q <= kind.high;
        end
    end

    // second cycle
    assign sum = (66'(pp_hh_q) <<< 32) + (66'(pp_hl_q) <<< 16)
               + (66'(pp_lh_q) <<< 16) + 66'(pp_ll_q);

    assign product = high_q ? sum[63:32] : sum[31:0];

endmodule

// File: exe_bypass.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_bypass (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 eu0_en,
    input  uop_pkg::itype_e      eu0_itype,
    input  logic                 eu1_en,
    input  uop_pkg::itype_e      eu1_itype,
    input  logic [`EXE_RA_W-1:0] eu0_rj,
    input  logic [`EXE_RA_W-1:0] eu0_rk,
    input  logic [`EXE_RA_W-1:0] eu1_rj,
    input  logic [`EXE_RA_W-1:0] eu1_rk,
    input  logic [`EXE_XLEN-1:0] eu0_rj_data,
    input  logic [`EXE_XLEN-1:0] eu0_rk_data,
    input  logic [`EXE_XLEN-1:0] eu1_rj_data,
    input  logic [`EXE_XLEN-1:0] eu1_rk_data,
    input  logic                 mid_en0,
    input  logic [`EXE_RA_W-1:0] mid_rd0,
    input  logic [`EXE_XLEN-1:0] mid_data0,
    input  pipe_pkg::fu_sel_e    mid_fu_sel0,
    input  logic                 mid_en1,
    input  logic [`EXE_RA_W-1:0] mid_rd1,
    input  logic [`EXE_XLEN-1:0] mid_data1,
    input  logic                 wb_en0,
    input  logic [`EXE_RA_W-1:0] wb_rd0,
    input  logic [`EXE_XLEN-1:0] wb_data0,
    input  logic                 wb_en1,
    input  logic [`EXE_RA_W-1:0] wb_rd1,
    input  logic [`EXE_XLEN-1:0] wb_data1,
    output logic [`EXE_XLEN-1:0] eu0_opj,
    output logic [`EXE_XLEN-1:0] eu0_opk,
    output logic [`EXE_XLEN-1:0] eu1_opj,
    output logic [`EXE_XLEN-1:0] eu1_opk,
    output logic                 stall
);
    import uop_pkg::*;
    import pipe_pkg::*;

    logic mid0_fwd;
    logic mid0_mul;
    logic eu0_reads;
    logic eu1_reads;

    // product is not ready while the mul sits in mid
    assign mid0_fwd = mid_en0 && (mid_fu_sel0 != FU_MUL);
    assign mid0_mul = mid_en0 && (mid_fu_sel0 == FU_MUL);

    // youngest result wins with lane 1 ahead of lane 0
    function automatic logic [`EXE_XLEN-1:0] pick(input logic [`EXE_RA_W-1:0] ra,
                                                  input logic [`EXE_XLEN-1:0] rf);
        if (ra == '0) return '0;
        if (mid_en1 && mid_rd1 == ra) return mid_data1;
        if (mid0_fwd && mid_rd0 == ra) return mid_data0;
        if (wb_en1 && wb_rd1 == ra) return wb_data1;
        if (wb_en0 && wb_rd0 == ra) return wb_data0;
        return rf;
    endfunction

    always_comb begin
        eu0_opj = pick(eu0_rj, eu0_rj_data);
        eu0_opk = pick(eu0_rk, eu0_rk_data);
        eu1_opj = pick(eu1_rj, eu1_rj_data);
        eu1_opk = pick(eu1_rk, eu1_rk_data);
    end

    assign eu0_reads = eu0_en && (eu0_itype != ITYPE_NONE);
    assign eu1_reads = eu1_en && (eu1_itype != ITYPE_NONE);

    assign stall = mid0_mul &&
                   ((eu0_reads && (eu0_rj == mid_rd0 || eu0_rk == mid_rd0)) ||
                    (eu1_reads && (eu1_rj == mid_rd0 || eu1_rk == mid_rd0)));

    // the bubble from mid clears the hazard on the next edge
    a_stall_single: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> !stall);

endmodule

// File: exe_mid_stage.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_mid_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 eu0_en,
    input  uop_pkg::itype_e      eu0_itype,
    input  uop_pkg::op_u         eu0_op,
    input  logic [`EXE_RA_W-1:0] eu0_rd,
    input  logic [`EXE_XLEN-1:0] eu0_pc,
    input  logic [`EXE_XLEN-1:0] eu0_alu_result,
    input  logic [`EXE_XLEN-1:0] eu0_link,
    input  logic                 eu1_en,
    input  uop_pkg::itype_e      eu1_itype,
    input  logic [`EXE_RA_W-1:0] eu1_rd,
    input  logic [`EXE_XLEN-1:0] eu1_pc,
    input  logic [`EXE_XLEN-1:0] eu1_alu_result,
    output logic                 mid_en0,
    output logic [`EXE_RA_W-1:0] mid_rd0,
    output logic [`EXE_XLEN-1:0] mid_pc0,
    output logic [`EXE_XLEN-1:0] mid_data0,
    output pipe_pkg::fu_sel_e    mid_fu_sel0,
    output logic                 mid_en1,
    output logic [`EXE_RA_W-1:0] mid_rd1,
    output logic [`EXE_XLEN-1:0] mid_pc1,
    output logic [`EXE_XLEN-1:0] mid_data1
);
    import uop_pkg::*;
    import pipe_pkg::*;

    fu_sel_e fu0;
    logic    links;
    logic    wr0;
    logic    wr1;

    always_comb begin
        case (eu0_itype)
            ITYPE_ALU: fu0 = FU_ALU;
            ITYPE_BR:  fu0 = FU_BR;
            ITYPE_MUL: fu0 = FU_MUL;
            default:   fu0 = FU_NONE;
        endcase
    end

    // only bl and jirl write a register
    assign links = (eu0_op.br == BR_BL) || (eu0_op.br == BR_JIRL);

    assign wr0 = eu0_en && !stall && (eu0_rd != '0) &&
                 ((fu0 == FU_ALU) || (fu0 == FU_MUL) || ((fu0 == FU_BR) && links));
    // mispredicted packet partner is dropped here
    assign wr1 = eu1_en && !stall && !flush && (eu1_rd != '0) && (eu1_itype == ITYPE_ALU);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid_en0     <= 1'b0;
            mid_en1     <= 1'b0;
            mid_fu_sel0 <= FU_NONE;
        end else begin
            mid_en0     <= wr0;
            mid_en1     <= wr1;
            mid_fu_sel0 <= stall ? FU_NONE : fu0;
        end
    end

    always_ff @(posedge clk) begin
        mid_rd0   <= eu0_rd;
        mid_pc0   <= eu0_pc;
        mid_data0 <= (fu0 == FU_BR) ? eu0_link : eu0_alu_result;
        mid_rd1   <= eu1_rd;
        mid_pc1   <= eu1_pc;
        mid_data1 <= eu1_alu_result;
    end

endmodule

// File: exe_wb_stage.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_wb_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 mid_en0,
    input  logic [`EXE_RA_W-1:0] mid_rd0,
    input  logic [`EXE_XLEN-1:0] mid_pc0,
    input  logic [`EXE_XLEN-1:0] mid_data0,
    input  pipe_pkg::fu_sel_e    mid_fu_sel0,
    input  logic                 mid_en1,
    input  logic [`EXE_RA_W-1:0] mid_rd1,
    input  logic [`EXE_XLEN-1:0] mid_pc1,
    input  logic [`EXE_XLEN-1:0] mid_data1,
    input  logic [`EXE_XLEN-1:0] product,
    output logic                 wb_en0,
    output logic [`EXE_RA_W-1:0] wb_rd0,
    output logic [`EXE_XLEN-1:0] wb_data0,
    output logic [`EXE_XLEN-1:0] wb_pc0,
    output logic                 wb_en1,
    output logic [`EXE_RA_W-1:0] wb_rd1,
    output logic [`EXE_XLEN-1:0] wb_data1,
    output logic [`EXE_XLEN-1:0] wb_pc1
);
    import pipe_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en0 <= 1'b0;
            wb_en1 <= 1'b0;
        end else begin
            wb_en0 <= mid_en0;
            wb_en1 <= mid_en1;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd0   <= mid_rd0;
        wb_pc0   <= mid_pc0;
        // multiplier finishes in the mid cycle
        wb_data0 <= (mid_fu_sel0 == FU_MUL) ? product : mid_data0;
        wb_rd1   <= mid_rd1;
        wb_pc1   <= mid_pc1;
        wb_data1 <= mid_data1;
    end

    // mid stage drops writes to r0
    a_mul_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        (mid_en0 && mid_fu_sel0 == FU_MUL) |=> (wb_rd0 != '0));

endmodule

// File: exe_top.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 eu0_en,
    input  uop_pkg::itype_e      eu0_itype,
    input  uop_pkg::op_u         eu0_op,
    input  logic                 eu0_src2_imm,
    input  logic [`EXE_RA_W-1:0] eu0_rd,
    input  logic [`EXE_RA_W-1:0] eu0_rj,
    input  logic [`EXE_RA_W-1:0] eu0_rk,
    input  logic [`EXE_XLEN-1:0] eu0_imm,
    input  logic [`EXE_XLEN-1:0] eu0_pc,
    input  logic [`EXE_XLEN-1:0] eu0_pc_next,
    input  logic [`EXE_XLEN-1:0] eu0_rj_data,
    input  logic [`EXE_XLEN-1:0] eu0_rk_data,
    input  logic                 eu1_en,
    input  uop_pkg::itype_e      eu1_itype,
    input  uop_pkg::op_u         eu1_op,
    input  logic                 eu1_src2_imm,
    input  logic [`EXE_RA_W-1:0] eu1_rd,
    input  logic [`EXE_RA_W-1:0] eu1_rj,
    input  logic [`EXE_RA_W-1:0] eu1_rk,
    input  logic [`EXE_XLEN-1:0] eu1_imm,
    input  logic [`EXE_XLEN-1:0] eu1_pc,
    input  logic [`EXE_XLEN-1:0] eu1_rj_data,
    input  logic [`EXE_XLEN-1:0] eu1_rk_data,
    output logic                 stall,
    output logic                 flush,
    output logic [`EXE_XLEN-1:0] redirect_pc,
    output logic                 br_valid,
    output logic                 br_taken,
    output logic [`EXE_XLEN-1:0] br_target,
    output logic                 wb_en0,
    output logic [`EXE_RA_W-1:0] wb_rd0,
    output logic [`EXE_XLEN-1:0] wb_data0,
    output logic [`EXE_XLEN-1:0] wb_pc0,
    output logic                 wb_en1,
    output logic [`EXE_RA_W-1:0] wb_rd1,
    output logic [`EXE_XLEN-1:0] wb_data1,
    output logic [`EXE_XLEN-1:0] wb_pc1
);
    import uop_pkg::*;
    import pipe_pkg::*;

    logic [`EXE_XLEN-1:0] eu0_opj;
    logic [`EXE_XLEN-1:0] eu0_opk;
    logic [`EXE_XLEN-1:0] eu1_opj;
    logic [`EXE_XLEN-1:0] eu1_opk;
    logic [`EXE_XLEN-1:0] eu0_alu_result;
    logic [`EXE_XLEN-1:0] eu1_alu_result;
    logic [`EXE_XLEN-1:0] br_link;
    logic [`EXE_XLEN-1:0] mul_product;
    logic                 mid_en0;
    logic [`EXE_RA_W-1:0] mid_rd0;
    logic [`EXE_XLEN-1:0] mid_pc0;
    logic [`EXE_XLEN-1:0] mid_data0;
    fu_sel_e              mid_fu_sel0;
    logic                 mid_en1;
    logic [`EXE_RA_W-1:0] mid_rd1;
    logic [`EXE_XLEN-1:0] mid_pc1;
    logic [`EXE_XLEN-1:0] mid_data1;

    exe_bypass u_bypass (
        .clk         (clk),
        .arst_n      (arst_n),
        .eu0_en      (eu0_en),
        .eu0_itype   (eu0_itype),
        .eu1_en      (eu1_en),
        .eu1_itype   (eu1_itype),
        .eu0_rj      (eu0_rj),
        .eu0_rk      (eu0_rk),
        .eu1_rj      (eu1_rj),
        .eu1_rk      (eu1_rk),
        .eu0_rj_data (eu0_rj_data),
        .eu0_rk_data (eu0_rk_data),
        .eu1_rj_data (eu1_rj_data),
        .eu1_rk_data (eu1_rk_data),
        .mid_en0     (mid_en0),
        .mid_rd0     (mid_rd0),
        .mid_data0   (mid_data0),
        .mid_fu_sel0 (mid_fu_sel0),
        .mid_en1     (mid_en1),
        .mid_rd1     (mid_rd1),
        .mid_data1   (mid_data1),
        .wb_en0      (wb_en0),
        .wb_rd0      (wb_rd0),
        .wb_data0    (wb_data0),
        .wb_en1      (wb_en1),
        .wb_rd1      (wb_rd1),
        .wb_data1    (wb_data1),
        .eu0_opj     (eu0_opj),
        .eu0_opk     (eu0_opk),
        .eu1_opj     (eu1_opj),
        .eu1_opk     (eu1_opk),
        .stall       (stall)
    );

    exe_alu u_alu0 (
        .en     (eu0_en && eu0_itype == ITYPE_ALU),
        .op     (eu0_op.alu),
        .a      (eu0_opj),
        .b      (eu0_src2_imm ? eu0_imm : eu0_opk),
        .result (eu0_alu_result)
    );

    exe_alu u_alu1 (
        .en     (eu1_en && eu1_itype == ITYPE_ALU),
        .op     (eu1_op.alu),
        .a      (eu1_opj),
        .b      (eu1_src2_imm ? eu1_imm : eu1_opk),
        .result (eu1_alu_result)
    );

    // resolves only when the packet is accepted
    exe_branch u_branch (
        .clk         (clk),
        .arst_n      (arst_n),
        .en          (eu0_en && eu0_itype == ITYPE_BR && !stall),
        .cond        (eu0_op.br),
        .pc          (eu0_pc),
        .pc_next     (eu0_pc_next),
        .imm         (eu0_imm),
        .a           (eu0_opj),
        .b           (eu0_opk),
        .valid       (br_valid),
        .taken       (br_taken),
        .target      (br_target),
        .link        (br_link),
        .mispredict  (flush),
        .redirect_pc (redirect_pc)
    );

    exe_mul u_mul (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (eu0_en && eu0_itype == ITYPE_MUL && !stall),
        .kind    (eu0_op.mul),
        .a       (eu0_opj),
        .b       (eu0_opk),
        .product (mul_product)
    );

    exe_mid_stage u_mid (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall          (stall),
        .flush          (flush),
        .eu0_en         (eu0_en),
        .eu0_itype      (eu0_itype),
        .eu0_op         (eu0_op),
        .eu0_rd         (eu0_rd),
        .eu0_pc         (eu0_pc),
        .eu0_alu_result (eu0_alu_result),
        .eu0_link       (br_link),
        .eu1_en         (eu1_en),
        .eu1_itype      (eu1_itype),
        .eu1_rd         (eu1_rd),
        .eu1_pc         (eu1_pc),
        .eu1_alu_result (eu1_alu_result),
        .mid_en0        (mid_en0),
        .mid_rd0        (mid_rd0),
        .mid_pc0        (mid_pc0),
        .mid_data0      (mid_data0),
        .mid_fu_sel0    (mid_fu_sel0),
        .mid_en1        (mid_en1),
        .mid_rd1        (mid_rd1),
        .mid_pc1        (mid_pc1),
        .mid_data1      (mid_data1)
    );

    exe_wb_stage u_wb (
        .clk         (clk),
        .arst_n      (arst_n),
        .mid_en0     (mid_en0),
        .mid_rd0     (mid_rd0),
        .mid_pc0     (mid_pc0),
        .mid_data0   (mid_data0),
        .mid_fu_sel0 (mid_fu_sel0),
        .mid_en1     (mid_en1),
        .mid_rd1     (mid_rd1),
        .mid_pc1     (mid_pc1),
        .mid_data1   (mid_data1),
        .product     (mul_product),
        .wb_en0      (wb_en0),
        .wb_rd0      (wb_rd0),
        .wb_data0    (wb_data0),
        .wb_pc0      (wb_pc0),
        .wb_en1      (wb_en1),
        .wb_rd1      (wb_rd1),
        .wb_data1    (wb_data1),
        .wb_pc1      (wb_pc1)
    );

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);
    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: tb_exe.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module tb_exe;
    import uop_pkg::*;

    localparam int N_RAND = 400;
    localparam int N_MUL  = 6;
    localparam int N_PKT  = N_RAND + N_MUL + 1;

    typedef struct packed {
        logic [`EXE_RA_W-1:0] rd;
        logic [`EXE_XLEN-1:0] data;
        logic [`EXE_XLEN-1:0] pc;
        int unsigned          cyc;
    } wb_exp_t;

    logic                 clk;
    logic                 arst_n;
    logic                 eu0_en;
    itype_e               eu0_itype;
    op_u                  eu0_op;
    logic                 eu0_src2_imm;
    logic [`EXE_RA_W-1:0] eu0_rd;
    logic [`EXE_RA_W-1:0] eu0_rj;
    logic [`EXE_RA_W-1:0] eu0_rk;
    logic [`EXE_XLEN-1:0] eu0_imm;
    logic [`EXE_XLEN-1:0] eu0_pc;
    logic [`EXE_XLEN-1:0] eu0_pc_next;
    logic [`EXE_XLEN-1:0] eu0_rj_data;
    logic [`EXE_XLEN-1:0] eu0_rk_data;
    logic                 eu1_en;
    itype_e               eu1_itype;
    op_u                  eu1_op;
    logic                 eu1_src2_imm;
    logic [`EXE_RA_W-1:0] eu1_rd;
    logic [`EXE_RA_W-1:0] eu1_rj;
    logic [`EXE_RA_W-1:0] eu1_rk;
    logic [`EXE_XLEN-1:0] eu1_imm;
    logic [`EXE_XLEN-1:0] eu1_pc;
    logic [`EXE_XLEN-1:0] eu1_rj_data;
    logic [`EXE_XLEN-1:0] eu1_rk_data;
    logic                 stall;
    logic                 flush;
    logic [`EXE_XLEN-1:0] redirect_pc;
    logic                 br_valid;
    logic                 br_taken;
    logic [`EXE_XLEN-1:0] br_target;
    logic                 wb_en0;
    logic [`EXE_RA_W-1:0] wb_rd0;
    logic [`EXE_XLEN-1:0] wb_data0;
    logic [`EXE_XLEN-1:0] wb_pc0;
    logic                 wb_en1;
    logic [`EXE_RA_W-1:0] wb_rd1;
    logic [`EXE_XLEN-1:0] wb_data1;
    logic [`EXE_XLEN-1:0] wb_pc1;

    // rf follows writeback for the DUT while mrf holds the architectural state
    logic [`EXE_XLEN-1:0] rf [32];
    logic [`EXE_XLEN-1:0] mrf [32];
    wb_exp_t              q0 [$];
    wb_exp_t              q1 [$];
    logic [31:0]          lfsr = 32'h1527264c;
    logic [`EXE_RA_W-1:0] mid_mul_rd;
    logic                 pred_ok;
    int unsigned          cycles;
    int                   err_count;

    tb_clkgen u_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    exe_top u_dut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BCD35C) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_LUI:  return b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [31:0] mul_ref(input mul_kind_t k, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] p;
        if (k.sgn) begin
            p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        end else begin
            p = {32'b0, a} * {32'b0, b};
        end
        return k.high ? p[63:32] : p[31:0];
    endfunction

    function automatic logic br_ref(input br_cond_e c, input logic [31:0] a,
                                    input logic [31:0] b);
        case (c)
            BR_JIRL, BR_B, BR_BL: return 1'b1;
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        err_count++;
        $display("FAILED %s got %h expected %h", name, got, exp);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_wb(input int lane, input logic [4:0] rd, input logic [31:0] data,
                            input logic [31:0] pc);
        wb_exp_t e;
        assert ((lane == 0 ? q0.size() : q1.size()) != 0)
        else report_error($sformatf("unexpected writeback on lane %0d", lane));
        if (lane == 0) begin
            e = q0.pop_front();
        end else begin
            e = q1.pop_front();
        end
        assert (cycles == e.cyc)
        else report_error($sformatf("lane %0d writeback arrived in the wrong cycle", lane));
        assert (rd == e.rd) else report_value($sformatf("wb_rd%0d", lane), rd, e.rd);
        assert (data == e.data) else report_value($sformatf("wb_data%0d", lane), data, e.data);
        assert (pc == e.pc) else report_value($sformatf("wb_pc%0d", lane), pc, e.pc);
        rf[rd] = data;
    endtask

    // lane 1 is checked last so it wins on equal rd
    always @(negedge clk) begin
        if (arst_n) begin
            if (wb_en0) begin
                check_wb(0, wb_rd0, wb_data0, wb_pc0);
            end
            if (wb_en1) begin
                check_wb(1, wb_rd1, wb_data1, wb_pc1);
            end
        end
    end

    task automatic gen_random_packet();
        eu0_en       = rnd(3) != 0;
        eu0_itype    = itype_e'(rnd(2));
        eu0_rd       = 5'(rnd(3));
        eu0_rj       = 5'(rnd(3));
        eu0_rk       = 5'(rnd(3));
        eu0_src2_imm = rnd(1);
        eu0_imm      = rnd(32);
        eu0_pc       = {rnd(30), 2'b00};
        case (eu0_itype)
            ITYPE_ALU: eu0_op.alu = alu_op_e'(rnd(4) % 12);
            ITYPE_BR:  eu0_op.br = br_cond_e'(3 + rnd(4) % 9);
            ITYPE_MUL: eu0_op = 4'(rnd(2) << 2);
            default:   eu0_op = 4'(rnd(4));
        endcase
        // short signed word offset for branches
        if (eu0_itype == ITYPE_BR) begin
            eu0_imm = {{18{eu0_imm[13]}}, eu0_imm[13:2], 2'b00};
        end
        pred_ok      = rnd(1);
        eu1_en       = rnd(1);
        eu1_itype    = rnd(2) != 0 ? ITYPE_ALU : ITYPE_NONE;
        eu1_op.alu   = alu_op_e'(rnd(4) % 12);
        eu1_rd       = 5'(rnd(3));
        eu1_rj       = 5'(rnd(3));
        eu1_rk       = 5'(rnd(3));
        eu1_src2_imm = rnd(1);
        eu1_imm      = rnd(32);
        eu1_pc       = eu0_pc + 4;
        // issue never pairs a lane 1 reader with the lane 0 writer
        if (eu0_en && eu0_itype != ITYPE_NONE && eu0_rd != '0) begin
            if (eu1_rj == eu0_rd) eu1_rj = '0;
            if (eu1_rk == eu0_rd) eu1_rk = '0;
        end
    endtask

    task automatic issue_packet();
        logic [31:0] a0;
        logic [31:0] b0;
        logic [31:0] target;
        logic [31:0] act;
        logic [31:0] res0;
        logic        taken;
        logic        isbr;
        logic        mis;
        logic        exp_stall;
        a0     = mrf[eu0_rj];
        b0     = mrf[eu0_rk];
        taken  = br_ref(eu0_op.br, a0, b0);
        target = (eu0_op.br == BR_JIRL) ? a0 + eu0_imm : eu0_pc + eu0_imm;
        act    = taken ? target : eu0_pc + 4;
        isbr   = eu0_en && eu0_itype == ITYPE_BR;
        eu0_pc_next = (isbr && !pred_ok) ? act + 4 : (isbr ? act : eu0_pc + 4);
        mis    = isbr && act != eu0_pc_next;
        eu0_rj_data = rf[eu0_rj];
        eu0_rk_data = rf[eu0_rk];
        eu1_rj_data = rf[eu1_rj];
        eu1_rk_data = rf[eu1_rk];
        exp_stall = mid_mul_rd != '0 &&
            ((eu0_en && eu0_itype != ITYPE_NONE && (eu0_rj == mid_mul_rd || eu0_rk == mid_mul_rd)) ||
             (eu1_en && eu1_itype != ITYPE_NONE && (eu1_rj == mid_mul_rd || eu1_rk == mid_mul_rd)));
        #14;
        assert (stall === exp_stall) else report_value("stall", stall, exp_stall);
        if (exp_stall) begin
            // a held packet resolves no branch
            assert (flush === 1'b0) else report_value("flush", flush, 1'b0);
            assert (br_valid === 1'b0) else report_value("br_valid", br_valid, 1'b0);
            @(negedge clk);
            #15;
            assert (stall === 1'b0) else report_error("stall held for more than one cycle");
        end
        assert (br_valid === isbr) else report_value("br_valid", br_valid, isbr);
        assert (flush === mis) else report_value("flush", flush, mis);
        if (isbr) begin
            assert (br_taken === taken) else report_value("br_taken", br_taken, taken);
            if (taken) begin
                assert (br_target === target) else report_value("br_target", br_target, target);
            end
        end
        if (mis) begin
            assert (redirect_pc === act) else report_value("redirect_pc", redirect_pc, act);
        end
        // architectural commit in lane order
        if (eu0_itype == ITYPE_ALU) begin
            res0 = alu_ref(eu0_op.alu, a0, eu0_src2_imm ? eu0_imm : b0);
        end else if (eu0_itype == ITYPE_MUL) begin
            res0 = mul_ref(eu0_op.mul, a0, b0);
        end else begin
            res0 = eu0_pc + 4;
        end
        if (eu0_en && eu0_rd != '0 && (eu0_itype == ITYPE_ALU || eu0_itype == ITYPE_MUL ||
            (isbr && (eu0_op.br == BR_BL || eu0_op.br == BR_JIRL)))) begin
            q0.push_back('{eu0_rd, res0, eu0_pc, cycles + 2});
            mrf[eu0_rd] = res0;
        end
        if (eu1_en && !mis && eu1_rd != '0 && eu1_itype == ITYPE_ALU) begin
            q1.push_back('{eu1_rd, alu_ref(eu1_op.alu, mrf[eu1_rj],
                           eu1_src2_imm ? eu1_imm : mrf[eu1_rk]), eu1_pc, cycles + 2});
            mrf[eu1_rd] = q1[$].data;
        end
        mid_mul_rd = (eu0_en && eu0_itype == ITYPE_MUL) ? eu0_rd : '0;
    endtask

    initial begin
        #((N_PKT * 8 + 20) * 40);
        $display("watchdog expired before all packets completed");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        {eu0_en, eu0_src2_imm, eu0_rd, eu0_rj, eu0_rk, eu0_imm, eu0_pc, eu0_pc_next} = '0;
        {eu0_rj_data, eu0_rk_data, eu1_rj_data, eu1_rk_data} = '0;
        {eu1_en, eu1_src2_imm, eu1_rd, eu1_rj, eu1_rk, eu1_imm, eu1_pc} = '0;
        eu0_itype  = ITYPE_NONE;
        eu1_itype  = ITYPE_NONE;
        eu0_op     = '0;
        eu1_op     = '0;
        mid_mul_rd = '0;
        pred_ok    = 1'b1;
        cycles     = 0;
        err_count  = 0;
        for (int i = 0; i < 32; i++) begin
            rf[i]  = '0;
            mrf[i] = '0;
        end
        wait (arst_n);
        @(negedge clk);
        #15;
        assert (!wb_en0 && !wb_en1 && !stall && !flush && !br_valid)
        else report_error("outputs not idle after reset");
        for (int n = 0; n < N_RAND; n++) begin
            @(negedge clk);
            #1;
            gen_random_packet();
            issue_packet();
        end
        // independent multiplies back to back and a dependent add at the end
        for (int n = 0; n <= N_MUL; n++) begin
            @(negedge clk);
            #1;
            eu1_en       = 1'b0;
            eu0_en       = 1'b1;
            eu0_itype    = (n < N_MUL) ? ITYPE_MUL : ITYPE_ALU;
            eu0_op       = (n < N_MUL) ? 4'(n % 4 << 2) : 4'(ALU_ADD);
            eu0_rd       = 5'(20 + n);
            eu0_rj       = (n < N_MUL) ? 5'(1 + n % 7) : 5'(19 + N_MUL);
            eu0_rk       = 5'(7 - n % 7);
            eu0_src2_imm = 1'b0;
            eu0_pc       = 32'h1000 + 32'(n * 8);
            issue_packet();
        end
        @(negedge clk);
        #1;
        eu0_en = 1'b0;
        eu1_en = 1'b0;
        repeat (4) @(negedge clk);
        #15;
        assert (q0.size() == 0 && q1.size() == 0)
        else report_error("expected writebacks never arrived");
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
uop_pkg.sv
pipe_pkg.sv
exe_alu.sv
exe_branch.sv
exe_mul.sv
exe_bypass.sv
exe_mid_stage.sv
exe_wb_stage.sv
exe_top.sv
tb_clkgen.sv
tb_exe.sv

// File: Bender.yml
package:
  name: exe_unit

export_include_dirs:
  - .

sources:
  - files:
      - uop_pkg.sv
      - pipe_pkg.sv
      - exe_alu.sv
      - exe_branch.sv
      - exe_mul.sv
      - exe_bypass.sv
      - exe_mid_stage.sv
      - exe_wb_stage.sv
      - exe_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_exe.sv
